// ==== sim.f ====
logic/rv_check_pkg.sv
logic/rv_inst_decoder.sv
logic/rv_legality_check.sv
logic/rv_writeback_checker.sv
logic/rv_branch_tracker.sv
logic/rv_retire_checker.sv
verif/tb_rv_retire_checker.sv

// ==== verif/tb_rv_retire_checker.sv ====
`timescale 1ns/1ps

module tb_rv_retire_checker;

    localparam int XLEN       = rv_check_pkg::XLEN;
    localparam int CLK_PERIOD = 10;
    // records per group, a blt group holds the branch, up to three bubbles and the successor
    localparam int N_RECORDS       = 20 + 21 + 12 + 50 + 10;
    localparam int WATCHDOG_CYCLES = 2000 + 20 * N_RECORDS;

    logic                                clk;
    logic                                rst;
    logic                                ret_valid;
    logic [XLEN-1:0]                     ret_pc;
    logic [XLEN-1:0]                     ret_inst;
    logic [XLEN-1:0]                     ret_rs1_val;
    logic [XLEN-1:0]                     ret_rs2_val;
    logic [XLEN-1:0]                     ret_mem_addr;
    logic [XLEN-1:0]                     ret_load_word;
    logic [XLEN-1:0]                     ret_wb_data;
    logic [rv_check_pkg::REG_ADDR_W-1:0] ret_wb_rd;
    logic                                ret_wb_we;
    logic                                err_valid_o;
    rv_check_pkg::err_code_t             err_code_o;
    logic [XLEN-1:0]                     err_pc_o;
    logic [rv_check_pkg::CNT_W-1:0]      checked_count_o;

    // expectation for the record on the inputs, and the one-deep slot behind it
    rv_check_pkg::err_code_t        exp_code_d;
    rv_check_pkg::err_code_t        exp_code_q;
    logic                           exp_valid_d;
    logic                           exp_valid_q;
    logic [XLEN-1:0]                exp_pc_d;
    logic [XLEN-1:0]                exp_pc_q;
    logic                           exp_inc_d;
    logic [rv_check_pkg::CNT_W-1:0] exp_count;
    logic [31:0]                    lfsr_state = 32'hc97ff16f;

    rv_retire_checker i_dut (
        .clk             (clk),
        .rst             (rst),
        .ret_valid_i     (ret_valid),
        .ret_pc_i        (ret_pc),
        .ret_inst_i      (ret_inst),
        .ret_rs1_val_i   (ret_rs1_val),
        .ret_rs2_val_i   (ret_rs2_val),
        .ret_mem_addr_i  (ret_mem_addr),
        .ret_load_word_i (ret_load_word),
        .ret_wb_data_i   (ret_wb_data),
        .ret_wb_rd_i     (ret_wb_rd),
        .ret_wb_we_i     (ret_wb_we),
        .err_valid_o     (err_valid_o),
        .err_code_o      (err_code_o),
        .err_pc_o        (err_pc_o),
        .checked_count_o (checked_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("FAIL @ %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [XLEN-1:0] rand_pc();
        return {30'(rand_bits(30)), 2'b00};
    endfunction

    function automatic logic [XLEN-1:0] widen_imm12(input logic [11:0] imm);
        return {{(XLEN-12){imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] i_format(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_format(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_format(input logic [2:0] f3, input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'(rv_check_pkg::OPC_B)};
    endfunction

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd3, 5'd4, f3, 5'd5, 7'(rv_check_pkg::OPC_R)};
    endfunction

    function automatic logic [7:0] fault_bit(input rv_check_pkg::err_code_t code);
        return 8'b1 << code;
    endfunction

    // reporting order of the faults present in one record
    function automatic rv_check_pkg::err_code_t highest_fault(input logic [7:0] faults);
        rv_check_pkg::err_code_t order [7] = '{
            rv_check_pkg::ERR_SPURIOUS_WE, rv_check_pkg::ERR_ILLEGAL,
            rv_check_pkg::ERR_BRANCH_TARGET, rv_check_pkg::ERR_MEM_ADDR,
            rv_check_pkg::ERR_WB_DATA, rv_check_pkg::ERR_WB_RD, rv_check_pkg::ERR_WB_WE};
        for (int i = 0; i < 7; i++) begin
            if (faults[order[i]]) return order[i];
        end
        return rv_check_pkg::ERR_NONE;
    endfunction

    function automatic logic counts_as_checked(input logic [31:0] inst);
        logic [6:0] opc;
        logic [2:0] f3;
        opc = inst[6:0];
        f3  = inst[14:12];
        return (opc == rv_check_pkg::OPC_I && f3 == rv_check_pkg::XORI) ||
               (opc == rv_check_pkg::OPC_IL && f3 == rv_check_pkg::LB) ||
               (opc == rv_check_pkg::OPC_B && f3 == rv_check_pkg::BLT) ||
               (opc == rv_check_pkg::OPC_AUIPC);
    endfunction

    // random filler for every record field, tests overwrite what they check
    task automatic fill_noise(input logic valid);
        ret_valid     = valid;
        ret_pc        = rand_pc();
        ret_inst      = rand_bits(32);
        ret_rs1_val   = rand_bits(32);
        ret_rs2_val   = rand_bits(32);
        ret_mem_addr  = rand_bits(32);
        ret_load_word = rand_bits(32);
        ret_wb_data   = rand_bits(32);
        ret_wb_rd     = 5'(rand_bits(5));
        ret_wb_we     = 1'b0;
    endtask

    task automatic issue(input logic [7:0] faults);
        exp_code_d  = highest_fault(faults);
        exp_valid_d = (exp_code_d != rv_check_pkg::ERR_NONE);
        exp_pc_d    = ret_pc;
        exp_inc_d   = ret_valid && counts_as_checked(ret_inst);
        @(posedge clk);
        #1;
    endtask

    task automatic plain_record(input logic [31:0] inst, input logic valid, input logic we,
                                input logic [7:0] faults);
        fill_noise(valid);
        ret_inst  = inst;
        ret_wb_we = we;
        issue(faults);
    endtask

    task automatic bubble();
        plain_record(rand_bits(32), 1'b0, 1'b0, '0);
    endtask

    task automatic xori_record(input logic [XLEN-1:0] pc, input logic corrupt,
                               input logic [7:0] extra);
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [7:0]  faults;
        rd     = 5'(rand_bits(5));
        imm    = 12'(rand_bits(12));
        faults = extra;
        fill_noise(1'b1);
        ret_pc      = pc;
        ret_inst    = i_format(rv_check_pkg::OPC_I, rv_check_pkg::XORI, rd, 5'd7, imm);
        ret_wb_data = ret_rs1_val ^ widen_imm12(imm);
        ret_wb_rd   = rd;
        ret_wb_we   = (rd != 5'd0);
        if (corrupt) begin
            ret_wb_data = ret_wb_data ^ (rand_bits(32) | 32'h1);
            faults      = faults | fault_bit(rv_check_pkg::ERR_WB_DATA);
        end
        issue(faults);
    endtask

    task automatic lb_record(input logic [1:0] offset, input logic neg, input logic addr_bad,
                             input logic rd_bad);
        logic [4:0]      rd;
        logic [11:0]     imm;
        logic [XLEN-1:0] addr;
        logic [7:0]      lane;
        logic [7:0]      faults;
        rd     = 5'(rand_bits(5)) | 5'd1;        // odd, so never x0
        imm    = 12'(rand_bits(12));
        faults = '0;
        fill_noise(1'b1);
        addr        = ret_rs1_val + widen_imm12(imm);
        ret_rs1_val = ret_rs1_val + {30'b0, offset} - {30'b0, addr[1:0]};
        addr        = ret_rs1_val + widen_imm12(imm);
        ret_load_word[8*offset+7] = neg;          // sign of the selected byte
        lane         = 8'(ret_load_word >> (8 * offset));
        ret_inst     = i_format(rv_check_pkg::OPC_IL, rv_check_pkg::LB, rd, 5'd9, imm);
        ret_mem_addr = addr;
        ret_wb_data  = {{(XLEN-8){lane[7]}}, lane};
        ret_wb_rd    = rd;
        ret_wb_we    = 1'b1;
        if (addr_bad) begin
            ret_mem_addr = addr + 32'd4;
            faults       = faults | fault_bit(rv_check_pkg::ERR_MEM_ADDR);
        end
        if (rd_bad) begin
            ret_wb_rd = rd ^ 5'd2;
            faults    = faults | fault_bit(rv_check_pkg::ERR_WB_RD);
        end
        issue(faults);
    endtask

    // mode 0 correct, 1 writes x0, 2 skips a nonzero rd
    task automatic auipc_record(input int mode);
        logic [4:0]  rd;
        logic [19:0] imm;
        logic [7:0]  faults;
        rd     = 5'(rand_bits(5));
        imm    = 20'(rand_bits(20));
        faults = '0;
        if (mode == 1) rd = 5'd0;
        if (mode == 2) rd = rd | 5'd1;
        fill_noise(1'b1);
        ret_inst    = u_format(rv_check_pkg::OPC_AUIPC, rd, imm);
        ret_wb_data = {imm, 12'b0} + ret_pc;
        ret_wb_rd   = rd;
        ret_wb_we   = (rd != 5'd0);
        if (mode != 0) begin
            ret_wb_we = !ret_wb_we;
            faults    = fault_bit(rv_check_pkg::ERR_WB_WE);
        end
        issue(faults);
    endtask

    task automatic blt_test(input logic taken, input int gap, input logic bad_pc);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] swap;
        logic [12:0]     off;
        logic [XLEN-1:0] next_pc;
        a   = rand_bits(32);
        b   = rand_bits(32);
        off = {11'(rand_bits(11)), 2'b00};
        if (a == b) b = b ^ 32'h1;
        if (($signed(a) < $signed(b)) != taken) begin
            swap = a;
            a    = b;
            b    = swap;
        end
        fill_noise(1'b1);
        ret_inst    = b_format(rv_check_pkg::BLT, off);
        ret_rs1_val = a;
        ret_rs2_val = b;
        next_pc     = taken ? ret_pc + {{(XLEN-13){off[12]}}, off} : ret_pc + 32'd4;
        issue('0);
        repeat (gap) bubble();
        if (bad_pc) begin
            // bad data too, the target fault outranks it
            xori_record(next_pc + 32'd8, 1'b1, fault_bit(rv_check_pkg::ERR_BRANCH_TARGET));
        end else begin
            xori_record(next_pc, 1'b0, '0);
        end
    endtask

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_valid_q <= 1'b0;
            exp_code_q  <= rv_check_pkg::ERR_NONE;
            exp_pc_q    <= '0;
            exp_count   <= '0;
        end else begin
            exp_valid_q <= exp_valid_d;
            exp_code_q  <= exp_code_d;
            exp_pc_q    <= exp_pc_d;
            if (exp_inc_d) exp_count <= exp_count + 1'b1;
        end
    end

    err_valid_check: assert property (@(posedge clk) disable iff (rst)
        err_valid_o == exp_valid_q)
        else flag_mismatch($sformatf("err_valid_o is %b, expected %b",
                                     $sampled(err_valid_o), $sampled(exp_valid_q)));

    err_code_check: assert property (@(posedge clk) disable iff (rst)
        err_code_o == exp_code_q)
        else flag_mismatch($sformatf("err_code_o is %0d, expected %0d",
                                     $sampled(err_code_o), $sampled(exp_code_q)));

    err_pc_check: assert property (@(posedge clk) disable iff (rst)
        exp_valid_q |-> err_pc_o == exp_pc_q)
        else flag_mismatch($sformatf("err_pc_o is %h, expected %h",
                                     $sampled(err_pc_o), $sampled(exp_pc_q)));

    count_check: assert property (@(posedge clk) disable iff (rst)
        checked_count_o == exp_count)
        else flag_mismatch($sformatf("checked_count_o is %0d, expected %0d",
                                     $sampled(checked_count_o), $sampled(exp_count)));

    initial begin
        rst         = 1'b1;
        exp_code_d  = rv_check_pkg::ERR_NONE;
        exp_valid_d = 1'b0;
        exp_pc_d    = '0;
        exp_inc_d   = 1'b0;
        fill_noise(1'b0);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < 16; i++) xori_record(rand_pc(), 1'b0, '0);
        for (int i = 0; i < 4; i++) xori_record(rand_pc(), 1'b1, '0);

        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 8; k++) lb_record(2'(k), k[2], 1'b0, 1'b0);
        end
        lb_record(2'd1, 1'b0, 1'b1, 1'b0);
        lb_record(2'd2, 1'b1, 1'b1, 1'b0);
        lb_record(2'd0, 1'b1, 1'b0, 1'b1);
        lb_record(2'd3, 1'b0, 1'b0, 1'b1);
        lb_record(2'd3, 1'b1, 1'b1, 1'b1);       // addr fault outranks rd fault

        for (int i = 0; i < 8; i++) auipc_record(0);
        for (int i = 0; i < 2; i++) auipc_record(1);
        for (int i = 0; i < 2; i++) auipc_record(2);

        for (int g = 0; g < 4; g++) begin
            blt_test(1'b1, g, 1'b0);
            blt_test(1'b0, g, 1'b0);
        end
        blt_test(1'b1, 2, 1'b1);
        blt_test(1'b0, 0, 1'b1);

        plain_record(i_format(rv_check_pkg::OPC_FENCE, 3'b000, 5'd0, 5'd0,
                              {4'b0000, 8'(rand_bits(8))}), 1'b1, 1'b0, '0);
        plain_record(i_format(rv_check_pkg::OPC_FENCE, 3'b001, 5'd0, 5'd0, 12'd0),
                     1'b1, 1'b0, '0);
        plain_record(32'h0000_0073, 1'b1, 1'b0, '0);   // ecall
        plain_record(32'h0010_0073, 1'b1, 1'b0, '0);   // ebreak
        plain_record(b_format(3'b010, 13'd8), 1'b1, 1'b0,
                     fault_bit(rv_check_pkg::ERR_ILLEGAL));
        plain_record(r_format(rv_check_pkg::FUNCT7_ALT, 3'b100), 1'b1, 1'b1,
                     fault_bit(rv_check_pkg::ERR_ILLEGAL));
        plain_record(rand_bits(32), 1'b0, 1'b1, fault_bit(rv_check_pkg::ERR_SPURIOUS_WE));
        // illegal word in a bubble is no fault, only the write counts
        plain_record(32'hffff_ffff, 1'b0, 1'b1, fault_bit(rv_check_pkg::ERR_SPURIOUS_WE));

        bubble();
        bubble();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== logic/rv_retire_checker.sv ====
`timescale 1ns/1ps

module rv_retire_checker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ret_valid_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_pc_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_inst_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_rs1_val_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_rs2_val_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_mem_addr_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_load_word_i,
    input  logic [rv_check_pkg::XLEN-1:0]       ret_wb_data_i,
    input  logic [rv_check_pkg::REG_ADDR_W-1:0] ret_wb_rd_i,
    input  logic                                ret_wb_we_i,
    output logic                                err_valid_o,
    output rv_check_pkg::err_code_t             err_code_o,
    output logic [rv_check_pkg::XLEN-1:0]       err_pc_o,
    output logic [rv_check_pkg::CNT_W-1:0]      checked_count_o
);

    rv_check_pkg::opcode_t               opcode;
    logic [rv_check_pkg::REG_ADDR_W-1:0] rd;
    logic [2:0]                          funct3;
    logic [6:0]                          funct7;
    logic [rv_check_pkg::XLEN-1:0]       imm_i;
    logic [rv_check_pkg::XLEN-1:0]       imm_b;
    logic [rv_check_pkg::XLEN-1:0]       imm_u;
    logic illegal_raw;    // not yet qualified by valid
    logic checked;
    logic addr_err;
    logic data_err;
    logic rd_err;
    logic we_err;
    logic is_branch;
    logic target_err;
    logic spurious_we;
    logic illegal;
    rv_check_pkg::err_code_t err_next;

    rv_inst_decoder u_decoder (
        .inst_i   (ret_inst_i),
        .opcode_o (opcode),
        .rd_o     (rd),
        .funct3_o (funct3),
        .funct7_o (funct7),
        .imm_i_o  (imm_i),
        .imm_b_o  (imm_b),
        .imm_u_o  (imm_u)
    );

    rv_legality_check u_legality (
        .inst_i    (ret_inst_i),
        .opcode_i  (opcode),
        .funct3_i  (funct3),
        .funct7_i  (funct7),
        .illegal_o (illegal_raw)
    );

    rv_writeback_checker u_wb_checker (
        .valid_i     (ret_valid_i),
        .opcode_i    (opcode),
        .funct3_i    (funct3),
        .rd_i        (rd),
        .imm_i_i     (imm_i),
        .imm_u_i     (imm_u),
        .pc_i        (ret_pc_i),
        .rs1_val_i   (ret_rs1_val_i),
        .mem_addr_i  (ret_mem_addr_i),
        .load_word_i (ret_load_word_i),
        .wb_data_i   (ret_wb_data_i),
        .wb_rd_i     (ret_wb_rd_i),
        .wb_we_i     (ret_wb_we_i),
        .checked_o   (checked),
        .addr_err_o  (addr_err),
        .data_err_o  (data_err),
        .rd_err_o    (rd_err),
        .we_err_o    (we_err)
    );

    rv_branch_tracker u_branch_tracker (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (ret_valid_i),
        .opcode_i     (opcode),
        .funct3_i     (funct3),
        .pc_i         (ret_pc_i),
        .imm_b_i      (imm_b),
        .rs1_val_i    (ret_rs1_val_i),
        .rs2_val_i    (ret_rs2_val_i),
        .is_branch_o  (is_branch),
        .target_err_o (target_err)
    );

    assign spurious_we = ret_wb_we_i && !ret_valid_i;  // bubble must not touch the rf
    assign illegal     = ret_valid_i && illegal_raw;

    // only the most severe fault of a record is reported
    always_comb begin
        if (spurious_we)     err_next = rv_check_pkg::ERR_SPURIOUS_WE;
        else if (illegal)    err_next = rv_check_pkg::ERR_ILLEGAL;
        else if (target_err) err_next = rv_check_pkg::ERR_BRANCH_TARGET;
        else if (addr_err)   err_next = rv_check_pkg::ERR_MEM_ADDR;
        else if (data_err)   err_next = rv_check_pkg::ERR_WB_DATA;
        else if (rd_err)     err_next = rv_check_pkg::ERR_WB_RD;
        else if (we_err)     err_next = rv_check_pkg::ERR_WB_WE;
        else                 err_next = rv_check_pkg::ERR_NONE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            err_valid_o     <= 1'b0;
            err_code_o      <= rv_check_pkg::ERR_NONE;
            checked_count_o <= '0;
        end else begin
            err_valid_o <= (err_next != rv_check_pkg::ERR_NONE);
            err_code_o  <= err_next;
            if (checked || is_branch) begin
                checked_count_o <= checked_count_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        err_pc_o <= ret_pc_i;
    end

    err_valid_has_code: assert property (
        @(posedge clk) disable iff (rst)
        err_valid_o |-> err_code_o != rv_check_pkg::ERR_NONE
    ) else $error("err_valid_o without an error code");

endmodule

// ==== logic/rv_branch_tracker.sv ====
`timescale 1ns/1ps

module rv_branch_tracker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid_i,
    input  rv_check_pkg::opcode_t         opcode_i,
    input  logic [2:0]                    funct3_i,
    input  logic [rv_check_pkg::XLEN-1:0] pc_i,
    input  logic [rv_check_pkg::XLEN-1:0] imm_b_i,
    input  logic [rv_check_pkg::XLEN-1:0] rs1_val_i,
    input  logic [rv_check_pkg::XLEN-1:0] rs2_val_i,
    output logic                          is_branch_o,
    output logic                          target_err_o
);

    localparam int XLEN = rv_check_pkg::XLEN;

    logic            blt_sel;
    logic            taken;
    logic [XLEN-1:0] next_pc;
    logic            pending_q;   // a blt retired, successor not seen yet
    logic [XLEN-1:0] expect_pc_q;

    assign blt_sel = valid_i && (opcode_i == rv_check_pkg::OPC_B) &&
                     (funct3_i == rv_check_pkg::BLT);

    assign taken   = $signed(rs1_val_i) < $signed(rs2_val_i);
    assign next_pc = taken ? (pc_i + imm_b_i) : (pc_i + XLEN'(4));

    // invalid cycles leave the pending state alone
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (valid_i) begin
            pending_q <= blt_sel;  // back to back blt reloads
        end
    end

    always_ff @(posedge clk) begin
        if (blt_sel) begin
            expect_pc_q <= next_pc;
        end
    end

    assign is_branch_o  = blt_sel;
    assign target_err_o = valid_i && pending_q && (pc_i != expect_pc_q);

    // a mismatch needs a prior blt that has not been resolved
    target_err_needs_pending: assert property (
        @(posedge clk) disable iff (rst)
        target_err_o |-> pending_q && $past(blt_sel || (pending_q && !valid_i))
    ) else $error("branch target error without a pending blt");

endmodule

// ==== logic/rv_writeback_checker.sv ====
`timescale 1ns/1ps

module rv_writeback_checker (
    input  logic                                valid_i,
    input  rv_check_pkg::opcode_t               opcode_i,
    input  logic [2:0]                          funct3_i,
    input  logic [rv_check_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv_check_pkg::XLEN-1:0]       imm_i_i,
    input  logic [rv_check_pkg::XLEN-1:0]       imm_u_i,
    input  logic [rv_check_pkg::XLEN-1:0]       pc_i,
    input  logic [rv_check_pkg::XLEN-1:0]       rs1_val_i,
    input  logic [rv_check_pkg::XLEN-1:0]       mem_addr_i,
    input  logic [rv_check_pkg::XLEN-1:0]       load_word_i,
    input  logic [rv_check_pkg::XLEN-1:0]       wb_data_i,
    input  logic [rv_check_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic                                wb_we_i,
    output logic                                checked_o,
    output logic                                addr_err_o,
    output logic                                data_err_o,
    output logic                                rd_err_o,
    output logic                                we_err_o
);

    localparam int XLEN = rv_check_pkg::XLEN;

    logic            xori_sel;
    logic            lb_sel;
    logic            auipc_sel;
    logic            any_sel;
    logic [XLEN-1:0] lb_addr;
    logic [7:0]      lb_byte;
    logic [XLEN-1:0] gold_data;
    logic            gold_we;

    assign xori_sel  = valid_i && (opcode_i == rv_check_pkg::OPC_I) &&
                       (funct3_i == rv_check_pkg::XORI);
    assign lb_sel    = valid_i && (opcode_i == rv_check_pkg::OPC_IL) &&
                       (funct3_i == rv_check_pkg::LB);
    assign auipc_sel = valid_i && (opcode_i == rv_check_pkg::OPC_AUIPC);
    assign any_sel   = xori_sel || lb_sel || auipc_sel;

    assign lb_addr = rs1_val_i + imm_i_i;

    // little endian byte lane picked by the low address bits
    always_comb begin
        case (lb_addr[1:0])
            2'd0:    lb_byte = load_word_i[7:0];
            2'd1:    lb_byte = load_word_i[15:8];
            2'd2:    lb_byte = load_word_i[23:16];
            default: lb_byte = load_word_i[31:24];
        endcase
    end

    always_comb begin
        gold_data = imm_u_i + pc_i;                         // auipc
        if (xori_sel) begin
            gold_data = rs1_val_i ^ imm_i_i;
        end else if (lb_sel) begin
            gold_data = {{(XLEN-8){lb_byte[7]}}, lb_byte};
        end
    end

    // x0 must never be written
    assign gold_we = (rd_i != '0);

    assign checked_o  = any_sel;
    assign addr_err_o = lb_sel && (mem_addr_i != lb_addr);
    assign data_err_o = any_sel && (wb_data_i != gold_data);
    assign rd_err_o   = any_sel && (wb_rd_i != rd_i);
    assign we_err_o   = any_sel && (wb_we_i != gold_we);

    // gold_data mux relies on at most one select per record
    sel_onehot: assert final ($onehot0({xori_sel, lb_sel, auipc_sel}))
        else $error("overlapping golden selects for opcode %b", opcode_i);

endmodule

// ==== logic/rv_legality_check.sv ====
`timescale 1ns/1ps

module rv_legality_check (
    input  logic [rv_check_pkg::XLEN-1:0] inst_i,
    input  rv_check_pkg::opcode_t         opcode_i,
    input  logic [2:0]                    funct3_i,
    input  logic [6:0]                    funct7_i,
    output logic                          illegal_o
);

    logic funct7_zero;
    logic funct7_alt;
    logic rd_rs1_zero;
    logic fence_ok;
    logic system_ok;

    assign funct7_zero = (funct7_i == 7'b0);
    assign funct7_alt  = (funct7_i == rv_check_pkg::FUNCT7_ALT);
    assign rd_rs1_zero = (inst_i[11:7] == 5'b0) && (inst_i[19:15] == 5'b0);

    // fence: fm of 0000 or 1000 (tso), fence.i: every field other than funct3 zero
    always_comb begin
        fence_ok = 1'b0;
        if (funct3_i == rv_check_pkg::FUNCT3_FENCE) begin
            fence_ok = rd_rs1_zero && (inst_i[30:28] == 3'b0);
        end else if (funct3_i == rv_check_pkg::FUNCT3_FENCE_I) begin
            fence_ok = rd_rs1_zero && (inst_i[31:20] == 12'b0);
        end
    end

    // ecall and ebreak differ only in bit 20
    assign system_ok = (inst_i[31:21] == 11'b0) && (inst_i[19:7] == 13'b0);

    always_comb begin
        illegal_o = 1'b1;
        case (opcode_i)
            rv_check_pkg::OPC_LUI,
            rv_check_pkg::OPC_AUIPC: illegal_o = 1'b0;
            rv_check_pkg::OPC_JAL:   illegal_o = inst_i[21];   // offset bit 1
            rv_check_pkg::OPC_JALR: begin
                illegal_o = (funct3_i != 3'b000) || (inst_i[21:20] != 2'b00);
            end
            rv_check_pkg::OPC_B: begin
                illegal_o = !(funct3_i inside {rv_check_pkg::BEQ, rv_check_pkg::BNE,
                                               rv_check_pkg::BLT, rv_check_pkg::BGE,
                                               rv_check_pkg::BLTU, rv_check_pkg::BGEU})
                            || inst_i[8];                       // offset bit 1
            end
            rv_check_pkg::OPC_IL: begin
                illegal_o = !(funct3_i inside {rv_check_pkg::LB, rv_check_pkg::LH,
                                               rv_check_pkg::LW, rv_check_pkg::LBU,
                                               rv_check_pkg::LHU});
            end
            rv_check_pkg::OPC_S: begin
                illegal_o = !(funct3_i inside {rv_check_pkg::SB, rv_check_pkg::SH,
                                               rv_check_pkg::SW});
            end
            rv_check_pkg::OPC_I: begin
                if (funct3_i == rv_check_pkg::SLLI) begin
                    illegal_o = !funct7_zero;
                end else if (funct3_i == rv_check_pkg::SRLI_SRAI) begin
                    illegal_o = !(funct7_zero || funct7_alt);
                end else begin
                    illegal_o = 1'b0;  // upper bits are immediate
                end
            end
            rv_check_pkg::OPC_R: begin
                // alt form only for sub and sra
                illegal_o = !(funct7_zero ||
                              (funct7_alt && (funct3_i == 3'b000 || funct3_i == 3'b101)));
            end
            rv_check_pkg::OPC_FENCE: illegal_o = !fence_ok;
            rv_check_pkg::OPC_E:     illegal_o = !system_ok;
            default:                 illegal_o = 1'b1;
        endcase
    end

endmodule

// ==== logic/rv_inst_decoder.sv ====
`timescale 1ns/1ps

module rv_inst_decoder (
    input  logic [rv_check_pkg::XLEN-1:0]       inst_i,
    output rv_check_pkg::opcode_t               opcode_o,
    output logic [rv_check_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [2:0]                          funct3_o,
    output logic [6:0]                          funct7_o,
    output logic [rv_check_pkg::XLEN-1:0]       imm_i_o,
    output logic [rv_check_pkg::XLEN-1:0]       imm_b_o,
    output logic [rv_check_pkg::XLEN-1:0]       imm_u_o
);

    localparam int XLEN = rv_check_pkg::XLEN;

    logic sign;  // shared sign bit of every immediate format

    assign sign = inst_i[31];

    // unknown encodings keep their raw value, legality check flags them
    assign opcode_o = rv_check_pkg::opcode_t'(inst_i[6:0]);
    assign rd_o     = inst_i[11:7];
    assign funct3_o = inst_i[14:12];
    assign funct7_o = inst_i[31:25];

    // i-type, 12 bits sign-extended
    assign imm_i_o = {{(XLEN-12){sign}}, inst_i[31:20]};

    // b-type offset is in halfwords, bit 0 implied zero
    assign imm_b_o = {
        {(XLEN-13){sign}},
        sign,
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // u-type fills the upper 20 bits
    assign imm_u_o = {inst_i[XLEN-1:12], 12'b0};

    // branch offsets must stay halfword aligned and keep the instruction's sign
    imm_b_format: assert final (imm_b_o[0] == 1'b0 && imm_b_o[XLEN-1] == sign)
        else $error("b immediate malformed for inst %h", inst_i);

endmodule

// ==== logic/rv_check_pkg.sv ====
package rv_check_pkg;

    localparam int XLEN       = 32;   // data and pc width
    localparam int REG_ADDR_W = 5;    // register index width
    localparam int CNT_W      = 16;   // checked instruction counter width

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub, sra, srai

    // fence family funct3 values
    localparam logic [2:0] FUNCT3_FENCE   = 3'b000;
    localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,  // register-register alu
        OPC_I     = 7'b0010011,  // immediate alu
        OPC_IL    = 7'b0000011,  // loads
        OPC_S     = 7'b0100011,  // stores
        OPC_B     = 7'b1100011,  // conditional branches
        OPC_JAL   = 7'b1101111,
        OPC_JALR  = 7'b1100111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111,
        OPC_E     = 7'b1110011   // ecall, ebreak
    } opcode_t;

    typedef enum logic [2:0] {
        ADDI      = 3'b000,
        SLLI      = 3'b001,
        SLTI      = 3'b010,
        SLTIU     = 3'b011,
        XORI      = 3'b100,
        SRLI_SRAI = 3'b101,  // funct7 picks logical or arithmetic
        ORI       = 3'b110,
        ANDI      = 3'b111
    } itype_funct3_t;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        SB = 3'b000,
        SH = 3'b001,
        SW = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_funct3_t;

    // listed in priority order, highest first after ERR_NONE
    typedef enum logic [2:0] {
        ERR_NONE          = 3'd0,
        ERR_SPURIOUS_WE   = 3'd1,
        ERR_ILLEGAL       = 3'd2,
        ERR_BRANCH_TARGET = 3'd3,
        ERR_MEM_ADDR      = 3'd4,
        ERR_WB_DATA       = 3'd5,
        ERR_WB_RD         = 3'd6,
        ERR_WB_WE         = 3'd7
    } err_code_t;

endpackage
